//--- hw/pow5_pkg.sv
`default_nettype none

package pow5_pkg;

    // ************************************************************************
    // datapath widths
    // ************************************************************************

    // operand and result width, results wrap modulo 2**POW5_W
    localparam int POW5_W = 8;

    typedef logic [POW5_W-1:0] pow5_data_t;

    // one seven-segment digit, {dot, g, f, e, d, c, b, a}, active high
    typedef logic [7:0] seg_t;

    // ************************************************************************
    // unit selection
    // ************************************************************************

    // code 2'd3 falls through to the pipelined unit
    typedef enum logic [1:0]
    {
        UNIT_SINGLE = 2'd0,
        UNIT_MULTI  = 2'd1,
        UNIT_PIPE   = 2'd2
    } unit_sel_t;

    // ************************************************************************
    // timing and display constants
    // ************************************************************************

    // clocks per enable strobe, small so simulation stays short
    localparam int POW5_CLK_EN_DIV = 4;
    localparam int POW5_DIV_W      = $clog2(POW5_CLK_EN_DIV);

    // multiply stages in the pipelined unit, n^2 .. n^5
    localparam int POW5_STAGES = 4;

    // hex digits per segment table, one nibble each
    localparam int SEG_TABLE_SIZE = 16;
    localparam int SEG_NIBBLE_W   = $clog2(SEG_TABLE_SIZE);

endpackage

`default_nettype wire

//--- hw/clk_en_divider.sv
`timescale 1ns/1ps
`default_nettype none

module clk_en_divider
(
    input  logic clk,
    input  logic rst_n,
    output logic clk_en
);

    import pow5_pkg::*;

    logic [POW5_DIV_W-1:0] cnt;
    logic                  wrap;

    // last count of the period
    assign wrap = (cnt == POW5_DIV_W'(POW5_CLK_EN_DIV - 1));

    // free-running count, strobe registered on wrap
    // so the first strobe lands POW5_CLK_EN_DIV clocks after reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt    <= '0;
            clk_en <= 1'b0;
        end
        else
        begin
            cnt    <= wrap ? '0 : cnt + POW5_DIV_W'(1);
            clk_en <= wrap;
        end
    end

    // strobe is a single clock wide
    a_clk_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en |=> !clk_en)
        else $error("clk_en held high for two clocks");

endmodule

`default_nettype wire

//--- hw/pow5_single_cycle.sv
`timescale 1ns/1ps
`default_nettype none

module pow5_single_cycle
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 n_vld,
    input  pow5_pkg::pow5_data_t n,
    output logic                 res_vld,
    output pow5_pkg::pow5_data_t res
);

    import pow5_pkg::*;

    logic       n_vld_q;
    pow5_data_t n_q;
    logic       prod_vld;
    pow5_data_t prod_q;

    // valid path, one flop per enabled edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            n_vld_q  <= 1'b0;
            prod_vld <= 1'b0;
            res_vld  <= 1'b0;
        end
        else if (clk_en)
        begin
            n_vld_q  <= n_vld;
            prod_vld <= n_vld_q;
            res_vld  <= prod_vld;
        end
    end

    // payload, follows the valid path
    always_ff @(posedge clk)
    begin
        if (clk_en)
        begin
            n_q    <= n;
            // all five factors in one enabled period
            prod_q <= n_q * n_q * n_q * n_q * n_q;
            // output flop keeps the long multiply off the display path
            res    <= prod_q;
        end
    end

    // a result only appears one strobe after its product was captured
    a_res_vld_after_prod: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(res_vld) |-> $past(clk_en) && $past(prod_vld))
        else $error("res_vld rose without a product valid one enabled period before");

endmodule

`default_nettype wire

//--- hw/pow5_multi_cycle.sv
`timescale 1ns/1ps
`default_nettype none

module pow5_multi_cycle
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 n_vld,
    input  pow5_pkg::pow5_data_t n,
    output logic                 res_vld,
    output pow5_pkg::pow5_data_t res
);

    import pow5_pkg::*;

    logic       n_vld_q;
    pow5_data_t n_q;
    // one-hot timer, top bit set on load, bit 0 marks n^5 ready
    logic [4:0] shift;
    pow5_data_t acc;

    // ************************************************************************
    // request capture
    // ************************************************************************

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            n_vld_q <= 1'b0;
        else if (clk_en)
            n_vld_q <= n_vld;
    end

    // operand held for the whole computation
    always_ff @(posedge clk)
    begin
        if (clk_en && n_vld)
            n_q <= n;
    end

    // ************************************************************************
    // sequencing and accumulate
    // ************************************************************************

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            shift <= 5'b0;
        else if (clk_en)
        begin
            // a new request always restarts
            if (n_vld_q)
                shift <= 5'b10000;
            else
                shift <= shift >> 1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (clk_en)
        begin
            if (n_vld_q)
                acc <= n_q;
            // four multiplies, then hold n^5 on the output
            else if (|shift[4:1])
                acc <= acc * n_q;
        end
    end

    assign res_vld = shift[0];
    assign res     = acc;

    // a restart must never leave two steps in flight
    a_shift_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(shift))
        else $error("multi-cycle timer holds more than one active step");

endmodule

`default_nettype wire

//--- hw/pow5_pipelined.sv
`timescale 1ns/1ps
`default_nettype none

module pow5_pipelined
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 n_vld,
    input  pow5_pkg::pow5_data_t n,
    output logic                 res_vld,
    output pow5_pkg::pow5_data_t res
);

    import pow5_pkg::*;

    logic                   n_vld_q;
    pow5_data_t             n_q;
    // stage i holds n^(i+2)
    pow5_data_t             pw [POW5_STAGES];
    // delayed copies of n, one per stage that still needs a factor
    pow5_data_t             nd [POW5_STAGES-1];
    logic [POW5_STAGES-1:0] vld_chain;

    // input flops, a new number every enabled edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            n_vld_q <= 1'b0;
        else if (clk_en)
            n_vld_q <= n_vld;
    end

    // valid chain moves in step with the data stages
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            vld_chain <= '0;
        else if (clk_en)
            vld_chain <= {vld_chain[POW5_STAGES-2:0], n_vld_q};
    end

    // ************************************************************************
    // multiply stages
    // ************************************************************************

    always_ff @(posedge clk)
    begin
        if (clk_en)
        begin
            n_q   <= n;
            pw[0] <= n_q * n_q;
            nd[0] <= n_q;
            for (int i = 1; i < POW5_STAGES; i++)
                pw[i] <= pw[i-1] * nd[i-1];
            for (int i = 1; i < POW5_STAGES - 1; i++)
                nd[i] <= nd[i-1];
        end
    end

    assign res_vld = vld_chain[POW5_STAGES-1];
    assign res     = pw[POW5_STAGES-1];

    // latency in clocks relies on the fixed strobe period of the divider
    a_pipe_vld_set: assert property (@(posedge clk) disable iff (!rst_n)
        (clk_en && n_vld_q) |-> ##(POW5_STAGES * POW5_CLK_EN_DIV) res_vld)
        else $error("pipelined valid lost before the last stage");

    a_pipe_vld_clr: assert property (@(posedge clk) disable iff (!rst_n)
        (clk_en && !n_vld_q) |-> ##(POW5_STAGES * POW5_CLK_EN_DIV) !res_vld)
        else $error("pipelined valid appeared without a request");

endmodule

`default_nettype wire

//--- hw/result_display.sv
`timescale 1ns/1ps
`default_nettype none

module result_display
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 res_vld,
    input  pow5_pkg::pow5_data_t res,
    output pow5_pkg::pow5_data_t held,
    output pow5_pkg::seg_t       seg_lo,
    output pow5_pkg::seg_t       seg_hi
);

    import pow5_pkg::*;

    // hex digit to segments, bit 0 is segment a, dot always off
    function automatic seg_t hex_to_seg(input logic [SEG_NIBBLE_W-1:0] nib);
        seg_t seg;
        case (nib)
            4'h0:    seg = 8'h3f;
            4'h1:    seg = 8'h06;
            4'h2:    seg = 8'h5b;
            4'h3:    seg = 8'h4f;
            4'h4:    seg = 8'h66;
            4'h5:    seg = 8'h6d;
            4'h6:    seg = 8'h7d;
            4'h7:    seg = 8'h07;
            4'h8:    seg = 8'h7f;
            4'h9:    seg = 8'h6f;
            4'ha:    seg = 8'h77;
            4'hb:    seg = 8'h7c;
            4'hc:    seg = 8'h39;
            4'hd:    seg = 8'h5e;
            4'he:    seg = 8'h79;
            4'hf:    seg = 8'h71;
            default: seg = 8'h00;
        endcase
        return seg;
    endfunction

    // last valid result, "00" shown out of reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            held <= '0;
        else if (clk_en && res_vld)
            held <= res;
    end

    // digits follow the held value in the same edge
    assign seg_lo = hex_to_seg(held[SEG_NIBBLE_W-1:0]);
    assign seg_hi = hex_to_seg(held[POW5_W-1:SEG_NIBBLE_W]);

endmodule

`default_nettype wire

//--- hw/pow5_top.sv
`timescale 1ns/1ps
`default_nettype none

module pow5_top
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [3:0]           key,
    input  pow5_pkg::pow5_data_t sw,
    output pow5_pkg::pow5_data_t led,
    output logic [7:0]           disp_en,
    output logic [31:0]          disp,
    output logic [7:0]           disp_dot
);

    import pow5_pkg::*;

    logic       clk_en;
    unit_sel_t  sel;

    logic       single_vld;
    pow5_data_t single_res;
    logic       multi_vld;
    pow5_data_t multi_res;
    logic       pipe_vld;
    pow5_data_t pipe_res;

    logic       sel_vld;
    pow5_data_t sel_res;
    seg_t       seg_lo;
    seg_t       seg_hi;

    // ************************************************************************
    // enable strobe and the three units
    // ************************************************************************

    clk_en_divider i_div
    (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .clk_en ( clk_en )
    );

    // key 0 is a level request, sw the operand, key 3 is spare
    pow5_single_cycle i_single
    (
        .clk     ( clk        ),
        .rst_n   ( rst_n      ),
        .clk_en  ( clk_en     ),
        .n_vld   ( key[0]     ),
        .n       ( sw         ),
        .res_vld ( single_vld ),
        .res     ( single_res )
    );

    pow5_multi_cycle i_multi
    (
        .clk     ( clk       ),
        .rst_n   ( rst_n     ),
        .clk_en  ( clk_en    ),
        .n_vld   ( key[0]    ),
        .n       ( sw        ),
        .res_vld ( multi_vld ),
        .res     ( multi_res )
    );

    pow5_pipelined i_pipe
    (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .clk_en  ( clk_en   ),
        .n_vld   ( key[0]   ),
        .n       ( sw       ),
        .res_vld ( pipe_vld ),
        .res     ( pipe_res )
    );

    // ************************************************************************
    // selection and display
    // ************************************************************************

    assign sel = unit_sel_t'(key[2:1]);

    // unused fourth code shows the pipeline
    always_comb
    begin
        case (sel)
            UNIT_SINGLE:
            begin
                sel_vld = single_vld;
                sel_res = single_res;
            end
            UNIT_MULTI:
            begin
                sel_vld = multi_vld;
                sel_res = multi_res;
            end
            default:
            begin
                sel_vld = pipe_vld;
                sel_res = pipe_res;
            end
        endcase
    end

    result_display i_disp
    (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .clk_en  ( clk_en  ),
        .res_vld ( sel_vld ),
        .res     ( sel_res ),
        .held    ( led     ),
        .seg_lo  ( seg_lo  ),
        .seg_hi  ( seg_hi  )
    );

    // two right-hand digits only
    assign disp     = {16'b0, seg_hi, seg_lo};
    assign disp_en  = 8'b00000011;
    // dot 0 flashes on a result, dot 1 shows the strobe
    assign disp_dot = {6'b0, clk_en, sel_vld};

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
    output logic clk
);

    // 4 ns period
    localparam int HALF_NS = 2;

    initial
    begin
        clk = 1'b0;
        forever
            #(HALF_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tests/tb_pow5_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pow5_top;

    import pow5_pkg::*;

    // ************************************************************************
    // run length and reference tables
    // ************************************************************************

    // request sequences, each given 10 enabled periods, then doubled
    localparam int N_TESTS    = 40;
    localparam int ENABLED_NS = POW5_CLK_EN_DIV * 4;
    localparam int TIMEOUT_NS = 2 * N_TESTS * 10 * ENABLED_NS;

    // hex digit to segments, {dot, g .. a}
    localparam seg_t SEG_TABLE [16] = '{
        8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
        8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71
    };

    logic        clk;
    logic        rst_n;
    logic [3:0]  key;
    pow5_data_t  sw;
    pow5_data_t  led;
    logic [7:0]  disp_en;
    logic [31:0] disp;
    logic [7:0]  disp_dot;

    int          errors;
    int          checks;
    logic [31:0] rand_state;
    // value the display should hold right now
    pow5_data_t  shown;
    pow5_data_t  ops [15];

    tb_clock i_clk
    (
        .clk ( clk )
    );

    pow5_top DUT
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key      ( key      ),
        .sw       ( sw       ),
        .led      ( led      ),
        .disp_en  ( disp_en  ),
        .disp     ( disp     ),
        .disp_dot ( disp_dot )
    );

    // ************************************************************************
    // reference model and helpers
    // ************************************************************************

    // n^5 mod 256 by plain integer arithmetic
    function automatic pow5_data_t pow5_ref(input pow5_data_t n);
        int r;
        r = 1;
        for (int i = 0; i < 5; i++)
            r = (r * int'(n)) % 256;
        return pow5_data_t'(r);
    endfunction

    // lcg, middle bits are the least periodic
    function automatic pow5_data_t next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[23:16];
    endfunction

    task automatic compare_data(input pow5_data_t got, input pow5_data_t exp,
                                input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at time %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic compare_seg(input seg_t got, input seg_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at time %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic expect_valid(input logic exp, input string what);
        checks++;
        if (exp && !disp_dot[0])
        begin
            errors++;
            $display("Error at time %0t: no result valid for %s", $time, what);
        end
        else if (!exp && disp_dot[0])
        begin
            errors++;
            $display("Fail at time %0t: unexpected result valid during %s", $time, what);
        end
    endtask

    // led plus both digits against the tb table
    task automatic check_display(input pow5_data_t exp, input string what);
        compare_data(led, exp, {what, " led"});
        compare_seg(disp[7:0], SEG_TABLE[exp[3:0]], {what, " low digit"});
        compare_seg(disp[15:8], SEG_TABLE[exp[7:4]], {what, " high digit"});
        // dots 2 to 7 are never lit
        compare_seg({disp_dot[7:2], 2'b00}, 8'h00, {what, " spare dots"});
    endtask

    // falling edge just before an enabled rising edge
    task automatic wait_strobe();
        @(negedge clk);
        while (!disp_dot[1])
            @(negedge clk);
    endtask

    // key 0 high for exactly one enabled edge
    task automatic send_request(input pow5_data_t n);
        wait_strobe();
        key[0] = 1'b1;
        sw     = n;
        wait_strobe();
        key[0] = 1'b0;
    endtask

    // called at the first strobe after the request edge
    task automatic wait_result(input int latency, input pow5_data_t exp, input string unit);
        int cnt;
        bit seen;
        cnt  = 1;
        seen = 1'b0;
        while (!seen && cnt <= latency + 2)
        begin
            if (disp_dot[0])
                seen = 1'b1;
            else
            begin
                wait_strobe();
                cnt++;
            end
        end
        checks++;
        if (!seen)
        begin
            errors++;
            $display("Error at time %0t: the %s unit gave no result valid within %0d periods",
                     $time, unit, latency + 2);
        end
        else
        begin
            if (cnt != latency)
            begin
                errors++;
                $display("Fail at time %0t: %s result shown after %0d enabled edges, expected %0d",
                         $time, unit, cnt, latency);
            end
            // display latches on the coming enabled edge
            @(negedge clk);
            shown = exp;
            check_display(exp, unit);
        end
    endtask

    // let every unit drain before the mux switches
    task automatic set_unit(input unit_sel_t u);
        repeat (8)
            wait_strobe();
        key[2:1] = u;
        repeat (2)
            wait_strobe();
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************

    task automatic reset_state();
        compare_data(led, 8'h00, "led after reset");
        compare_seg(disp[7:0], SEG_TABLE[0], "low digit after reset");
        compare_seg(disp[15:8], SEG_TABLE[0], "high digit after reset");
        compare_seg(disp[23:16], 8'h00, "unused digit 2");
        compare_seg(disp[31:24], 8'h00, "unused digit 3");
        compare_seg(disp_en, 8'b00000011, "digit enables");
        // strobe dot low, spare dots off
        compare_seg({disp_dot[7:1], 1'b0}, 8'h00, "dots after reset");
        expect_valid(1'b0, "reset");
    endtask

    // corner operands first, then ten from the lcg
    task automatic build_operands();
        ops[0] = 8'd0;
        ops[1] = 8'd1;
        ops[2] = 8'd2;
        ops[3] = 8'd3;
        ops[4] = 8'd255;
        for (int i = 5; i < 15; i++)
            ops[i] = next_rand();
    endtask

    task automatic single_unit_results();
        set_unit(UNIT_SINGLE);
        for (int i = 0; i < 15; i++)
        begin
            send_request(ops[i]);
            wait_result(3, pow5_ref(ops[i]), "single-cycle");
        end
    endtask

    task automatic multi_unit_results();
        set_unit(UNIT_MULTI);
        for (int i = 0; i < 15; i++)
        begin
            send_request(ops[i]);
            wait_result(6, pow5_ref(ops[i]), "multi-cycle");
        end
    endtask

    // second request two enabled periods later wins
    task automatic multi_restart();
        set_unit(UNIT_MULTI);
        send_request(8'd3);
        send_request(8'd2);
        wait_result(6, pow5_ref(8'd2), "restarted multi-cycle");
    endtask

    // strobe s drives request s, its result is seen at strobe s+5
    task automatic pipeline_burst();
        pow5_data_t burst [8];
        for (int i = 0; i < 8; i++)
            burst[i] = next_rand();
        set_unit(UNIT_PIPE);
        for (int s = 0; s < 14; s++)
        begin
            wait_strobe();
            if (s >= 6)
                shown = pow5_ref(burst[s-6]);
            check_display(shown, "pipeline");
            expect_valid(s >= 5 && s <= 12, "the pipeline burst");
            key[0] = (s < 8);
            if (s < 8)
                sw = burst[s];
        end
    endtask

    // one clock of key 0 between strobes, must be missed
    task automatic short_key_pulse(input unit_sel_t u);
        set_unit(u);
        wait_strobe();
        @(negedge clk);
        key[0] = 1'b1;
        sw     = 8'h03;
        @(negedge clk);
        key[0] = 1'b0;
        repeat (8)
        begin
            wait_strobe();
            expect_valid(1'b0, "a short key pulse");
            check_display(shown, "held");
        end
    endtask

    // ************************************************************************
    // main sequence and watchdog
    // ************************************************************************

    initial
    begin
        rst_n      = 1'b0;
        key        = '0;
        sw         = '0;
        errors     = 0;
        checks     = 0;
        rand_state = 32'd52;
        shown      = '0;
        repeat (2)
            @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        build_operands();
        single_unit_results();
        multi_unit_results();
        multi_restart();
        pipeline_burst();
        short_key_pulse(UNIT_SINGLE);
        short_key_pulse(UNIT_MULTI);
        short_key_pulse(UNIT_PIPE);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/pow5_pkg.sv
hw/clk_en_divider.sv
hw/pow5_single_cycle.sv
hw/pow5_multi_cycle.sv
hw/pow5_pipelined.sv
hw/result_display.sv
hw/pow5_top.sv
tests/tb_clock.sv
tests/tb_pow5_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pow5 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pow5_top -f filelist.f

out=$(./obj_dir/Vtb_pow5_top)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi
